/* source/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Datapath width
`define ALU_DATA_W 32

////////////////////////////////////////
// Instruction field bounds
////////////////////////////////////////

// Major opcode
`define ALU_OPC_MSB 31
`define ALU_OPC_LSB 26
// Destination register
`define ALU_RD_MSB 25
`define ALU_RD_LSB 21
// Shift amount, register form only
`define ALU_SHAMT_MSB 15
`define ALU_SHAMT_LSB 11
// Immediate, sits at bit 0
`define ALU_IMM_MSB 15
// ALU code, sits at bit 0
`define ALU_FUNCT_MSB 3

// Opcode values
`define ALU_OPC_REG 6'd0
`define ALU_OPC_ADDI 6'd1

`endif

/* source/alu_pkg.sv */
`include "alu_defines.svh"

package alu_pkg;

	////////////////////////////////////////
	// ALU codes
	////////////////////////////////////////

	// Low codes pick one unit each
	// Any code with bit 3 set is a shift
	typedef enum logic [3:0] {
		code_pass       = 4'b0000,
		code_add        = 4'b0001,
		code_and        = 4'b0010,
		code_xor        = 4'b0011,
		code_diff       = 4'b0100,
		code_comp       = 4'b0101,
		code_shift_base = 4'b1000
	} alu_code_t;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////

	// Decode to execute
	typedef struct packed {
		logic                   valid;
		alu_code_t              code;
		logic [`ALU_DATA_W-1:0] a;
		// Immediate already folded in for addi
		logic [`ALU_DATA_W-1:0] b;
		logic [4:0]             shamt;
		logic [4:0]             rd;
		// Only add and addi touch carry
		logic                   writes_carry;
	} exec_req_t;

	// Execute to result
	typedef struct packed {
		logic                   valid;
		logic [`ALU_DATA_W-1:0] value;
		// Adder carry, meaningful only with writes_carry
		logic                   carry_out;
		logic                   writes_carry;
		logic [4:0]             rd;
	} exec_res_t;

	// Cluster output, flags per result
	typedef struct packed {
		logic [`ALU_DATA_W-1:0] value;
		logic                   zero;
		logic                   sign;
		// Carry register after this instruction
		logic                   carry;
		logic [4:0]             rd;
	} alu_out_t;

endpackage

/* source/alu_shifter.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_shifter (
	input  logic [31:0] data,
	input  logic [4:0]  amount,
	input  logic        left,
	input  logic        logical,
	output logic [31:0] shifted
);

	// One entry per barrel stage, entry 0 is the input
	logic [`ALU_DATA_W-1:0] stage [0:5];
	logic                   fill;

	// Sign fill only for right arithmetic
	assign fill = !left && !logical && data[`ALU_DATA_W-1];

	assign stage[0] = data;

	////////////////////////////////////////
	// Log stages, 1 2 4 8 16
	////////////////////////////////////////

	for (genvar k = 0; k < 5; k++) begin : g_stage
		localparam int STEP = 1 << k;

		always_comb begin
			if (!amount[k]) begin
				stage[k+1] = stage[k];
			end else if (left) begin
				// Left arithmetic same as left logical
				stage[k+1] = {stage[k][`ALU_DATA_W-1-STEP:0], {STEP{1'b0}}};
			end else begin
				stage[k+1] = {{STEP{fill}}, stage[k][`ALU_DATA_W-1:STEP]};
			end
		end
	end

	assign shifted = stage[5];

endmodule

/* source/alu_decode.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_decode (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  logic [31:0]        instr,
	input  logic [31:0]        op_a,
	input  logic [31:0]        op_b,
	output alu_pkg::exec_req_t dec_req,
	output logic               illegal
);
	import alu_pkg::*;

	logic [`ALU_OPC_MSB-`ALU_OPC_LSB:0] opcode;
	alu_code_t                          funct;
	logic [`ALU_DATA_W-1:0]             imm_ext;
	logic                               is_reg;
	logic                               is_addi;
	logic                               funct_ok;
	logic                               legal;
	exec_req_t                          req_next;

	////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////

	assign opcode = instr[`ALU_OPC_MSB:`ALU_OPC_LSB];
	assign funct = alu_code_t'(instr[`ALU_FUNCT_MSB:0]);

	// Sign extend the 16-bit immediate
	assign imm_ext = {{(`ALU_DATA_W - `ALU_IMM_MSB - 1){instr[`ALU_IMM_MSB]}},
		instr[`ALU_IMM_MSB:0]};

	assign is_reg = (opcode == `ALU_OPC_REG);
	assign is_addi = (opcode == `ALU_OPC_ADDI);

	// Shifts all legal, 0110 and 0111 unused
	assign funct_ok = funct[3] || (funct[2:1] != 2'b11);
	assign legal = is_addi || (is_reg && funct_ok);

	////////////////////////////////////////
	// Request build
	////////////////////////////////////////

	always_comb begin
		req_next.valid = instr_valid && legal;
		// addi runs as a plain add
		req_next.code = is_addi ? code_add : funct;
		req_next.a = op_a;
		req_next.b = is_addi ? imm_ext : op_b;
		req_next.shamt = instr[`ALU_SHAMT_MSB:`ALU_SHAMT_LSB];
		req_next.rd = instr[`ALU_RD_MSB:`ALU_RD_LSB];
		// Complement uses the adder but keeps carry
		req_next.writes_carry = is_addi || (funct == code_add);
	end

	// Payload loads every cycle, only valid is cleared
	always_ff @(posedge clk) begin
		dec_req <= req_next;
		if (reset) begin
			dec_req.valid <= 1'b0;
		end
	end

	// One-cycle pulse per rejected instruction
	always_ff @(posedge clk) begin
		if (reset) begin
			illegal <= 1'b0;
		end else begin
			illegal <= instr_valid && !legal;
		end
	end

	// Rejected instruction never enters execute
	a_no_valid_on_illegal: assert property (
		@(posedge clk) disable iff (reset)
		!(dec_req.valid && illegal)
	);

endmodule

/* source/alu_execute.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_execute (
	input  logic               clk,
	input  logic               reset,
	input  alu_pkg::exec_req_t dec_req,
	output alu_pkg::exec_res_t ex_res
);
	import alu_pkg::*;

	logic                   sel_comp;
	logic [`ALU_DATA_W-1:0] add_a;
	logic [`ALU_DATA_W-1:0] add_b;
	logic [`ALU_DATA_W:0]   sum;
	logic [`ALU_DATA_W-1:0] res_and;
	logic [`ALU_DATA_W-1:0] res_xor;
	logic [5:0]             diff_idx;
	logic [4:0]             shift_amt;
	logic [`ALU_DATA_W-1:0] shift_val;
	logic [`ALU_DATA_W-1:0] value_next;

	////////////////////////////////////////
	// Operand muxing
	////////////////////////////////////////

	// Complement computed as 1 + ~b on the adder
	assign sel_comp = (dec_req.code == code_comp);
	assign add_a = sel_comp ? `ALU_DATA_W'(1) : dec_req.a;
	assign add_b = sel_comp ? ~dec_req.b : dec_req.b;

	// Code bit 2 picks b[4:0], else shamt field
	assign shift_amt = dec_req.code[2] ? dec_req.b[4:0] : dec_req.shamt;

	////////////////////////////////////////
	// Functional units
	////////////////////////////////////////

	// 33-bit add, top bit is carry out
	assign sum = {1'b0, add_a} + {1'b0, add_b};

	assign res_and = dec_req.a & dec_req.b;
	assign res_xor = dec_req.a ^ dec_req.b;

	// Lowest differing bit wins, 32 when equal
	always_comb begin
		diff_idx = 6'd32;
		for (int i = `ALU_DATA_W - 1; i >= 0; i--) begin
			if (dec_req.a[i] ^ dec_req.b[i]) begin
				diff_idx = 6'(i);
			end
		end
	end

	// Bit 1 left, bit 0 logical
	alu_shifter u_shifter (
		.data    (dec_req.a),
		.amount  (shift_amt),
		.left    (dec_req.code[1]),
		.logical (dec_req.code[0]),
		.shifted (shift_val)
	);

	////////////////////////////////////////
	// Result select
	////////////////////////////////////////

	always_comb begin
		if (dec_req.code >= code_shift_base) begin
			value_next = shift_val;
		end else begin
			case (dec_req.code)
				code_add,
				code_comp: value_next = sum[`ALU_DATA_W-1:0];
				code_and:  value_next = res_and;
				code_xor:  value_next = res_xor;
				code_diff: value_next = {{(`ALU_DATA_W - 6){1'b0}}, diff_idx};
				// Pass operand a
				default:   value_next = dec_req.a;
			endcase
		end
	end

	// Stage register, valid cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_res.valid <= 1'b0;
		end else begin
			ex_res.valid <= dec_req.valid;
		end
		ex_res.value <= value_next;
		ex_res.carry_out <= sum[`ALU_DATA_W];
		ex_res.writes_carry <= dec_req.writes_carry;
		ex_res.rd <= dec_req.rd;
	end

	// Decode filters 0110 and 0111 before they reach here
	a_legal_code: assert property (
		@(posedge clk) disable iff (reset)
		ex_res.valid |-> ($past(dec_req.code[3]) || ($past(dec_req.code[2:1]) != 2'b11))
	);

endmodule

/* source/alu_result.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_result (
	input  logic               clk,
	input  logic               reset,
	input  alu_pkg::exec_res_t ex_res,
	output logic               result_valid,
	output alu_pkg::alu_out_t  result
);
	import alu_pkg::*;

	logic carry_q;
	logic carry_new;
	logic zero;
	logic sign;

	////////////////////////////////////////
	// Flags
	////////////////////////////////////////

	assign zero = (ex_res.value == '0);
	assign sign = ex_res.value[`ALU_DATA_W-1];

	// Carry seen by this instruction, after its own update
	assign carry_new = ex_res.writes_carry ? ex_res.carry_out : carry_q;

	// Carry flag, only add and addi write it
	always_ff @(posedge clk) begin
		if (reset) begin
			carry_q <= 1'b0;
		end else if (ex_res.valid && ex_res.writes_carry) begin
			carry_q <= ex_res.carry_out;
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= ex_res.valid;
		end
	end

	// Payload holds between results
	always_ff @(posedge clk) begin
		if (ex_res.valid) begin
			result.value <= ex_res.value;
			result.zero <= zero;
			result.sign <= sign;
			result.carry <= carry_new;
			result.rd <= ex_res.rd;
		end
	end

	// Valid chain clean once out of reset
	a_valid_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(result_valid)
	);

endmodule

/* source/alu_top.sv */
`timescale 1ns/1ps

module alu_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              instr_valid,
	input  logic [31:0]       instr,
	input  logic [31:0]       op_a,
	input  logic [31:0]       op_b,
	output logic              result_valid,
	output alu_pkg::alu_out_t result,
	output logic              illegal
);
	import alu_pkg::*;

	// Stage-to-stage payloads
	exec_req_t dec_req;
	exec_res_t ex_res;

	////////////////////////////////////////
	// Three stages, one cycle each
	////////////////////////////////////////

	alu_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.op_a        (op_a),
		.op_b        (op_b),
		.dec_req     (dec_req),
		.illegal     (illegal)
	);

	alu_execute u_execute (
		.clk     (clk),
		.reset   (reset),
		.dec_req (dec_req),
		.ex_res  (ex_res)
	);

	// Flags and carry register
	alu_result u_result (
		.clk          (clk),
		.reset        (reset),
		.ex_res       (ex_res),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* sim/alu_tb.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_tb;
	import alu_pkg::*;

	// Expected outcome of one issued instruction
	typedef struct packed {
		logic     illegal;
		alu_out_t out;
	} expect_t;

	localparam int RESET_CYCLES = 5;
	localparam int N_RANDOM = 300;
	// Directed tests issue 93 instructions, rounded up
	localparam int N_DIRECTED = 100;
	localparam int N_TESTS = 6;
	localparam int DRAIN_CYCLES = 8;
	localparam int CYCLE_LIMIT = RESET_CYCLES + N_DIRECTED + N_RANDOM
		+ N_TESTS * (DRAIN_CYCLES + 1) + 3 + 50;
	// Cycles from presenting an instruction to its response
	localparam int RESULT_LATENCY = 3;
	localparam int ILLEGAL_LATENCY = 1;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic        result_valid;
	alu_out_t    result;
	logic        illegal;

	alu_out_t    res_q [$];
	// Issue cycle of each outstanding result and rejected instruction
	int          res_cyc_q [$];
	int          ill_q [$];
	alu_out_t    exp_out;
	int          issued_at;
	logic        model_carry = 1'b0;
	integer      seed = 32'h4108;
	int          pass_count = 0;
	int          fail_count = 0;
	int          cycle_count = 0;

	alu_top dut (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.op_a         (op_a),
		.op_b         (op_b),
		.result_valid (result_valid),
		.result       (result),
		.illegal      (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////

	function automatic logic [31:0] reg_form(input logic [4:0] rd, input logic [3:0] code,
		input logic [4:0] shamt);
		return {`ALU_OPC_REG, rd, 5'd0, shamt, 7'd0, code};
	endfunction

	function automatic logic [31:0] addi_form(input logic [4:0] rd, input logic [15:0] imm);
		return {`ALU_OPC_ADDI, rd, 5'd0, imm};
	endfunction

	// Would be an add if the opcode were accepted
	function automatic logic [31:0] bad_opcode(input logic [5:0] opc, input logic [4:0] rd);
		return {opc, rd, 17'd0, 4'b0001};
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic expect_t ref_model(input logic [31:0] ins, input logic [31:0] a,
		input logic [31:0] b);
		expect_t     e;
		logic [5:0]  opc;
		logic [3:0]  code;
		logic [31:0] bb;
		logic [4:0]  amt;
		logic [32:0] wide;
		logic [31:0] v;
		logic        found;
		opc = ins[31:26];
		code = ins[3:0];
		bb = b;
		v = 32'd0;
		e = '0;
		// addi forces an add with the immediate as b
		if (opc == 6'd1) begin
			code = 4'b0001;
			bb = {{16{ins[15]}}, ins[15:0]};
		end
		if ((opc > 6'd1) || (!code[3] && code[2:1] == 2'b11)) begin
			e.illegal = 1'b1;
			return e;
		end
		if (code[3]) begin
			amt = code[2] ? bb[4:0] : ins[15:11];
			if (code[1])
				v = a << amt;
			else if (code[0])
				v = a >> amt;
			else
				v = $unsigned($signed(a) >>> amt);
		end else begin
			case (code)
				4'b0001: begin
					wide = {1'b0, a} + {1'b0, bb};
					v = wide[31:0];
					model_carry = wide[32];
				end
				4'b0010: v = a & bb;
				4'b0011: v = a ^ bb;
				4'b0100: begin
					// Scan upward, first mismatch wins
					v = 32'd32;
					found = 1'b0;
					for (int i = 0; i < 32; i++) begin
						if (!found && (a[i] != bb[i])) begin
							v = 32'(i);
							found = 1'b1;
						end
					end
				end
				4'b0101: v = 32'd0 - bb;
				default: v = a;
			endcase
		end
		e.out.value = v;
		e.out.zero = (v == 32'd0);
		e.out.sign = v[31];
		e.out.carry = model_carry;
		e.out.rd = ins[25:21];
		return e;
	endfunction

	////////////////////////////////////////
	// Stimulus and bookkeeping
	////////////////////////////////////////

	task automatic issue_instr(input logic [31:0] ins, input logic [31:0] a,
		input logic [31:0] b);
		expect_t e;
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr = ins;
		op_a = a;
		op_b = b;
		e = ref_model(ins, a, b);
		if (e.illegal) begin
			ill_q.push_back(cycle_count);
		end else begin
			res_q.push_back(e.out);
			res_cyc_q.push_back(cycle_count);
		end
	endtask

	// Stop issuing, wait for everything in flight
	task automatic drain_pipeline();
		int waited;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		waited = 0;
		while ((res_q.size() + ill_q.size()) > 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		assert (res_q.size() == 0 && ill_q.size() == 0) else begin
			$display("%0d results and %0d illegal pulses never arrived",
				res_q.size(), ill_q.size());
			fail_count++;
		end
		res_q.delete();
		res_cyc_q.delete();
		ill_q.delete();
	endtask

	task automatic check_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) begin
			pass_count++;
		end else begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			fail_count++;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("Test %s: %s, %0d failed checks", name,
			(fail_count == fails_before) ? "clean" : "errors", fail_count - fails_before);
	endtask

	////////////////////////////////////////
	// Comparator
	////////////////////////////////////////

	// Outputs settle after the rising edge, sample on the falling one
	always @(negedge clk) begin
		if (!reset) begin
			if (illegal) begin
				assert (ill_q.size() > 0) else begin
					$display("Illegal pulse with no rejected instruction outstanding");
					fail_count++;
				end
				if (ill_q.size() > 0) begin
					issued_at = ill_q.pop_front();
					assert ((cycle_count - issued_at) == ILLEGAL_LATENCY) else begin
						$display("Illegal pulse came %0d cycles after its instruction, not %0d",
							cycle_count - issued_at, ILLEGAL_LATENCY);
						fail_count++;
					end
				end
			end
			if (result_valid) begin
				assert (res_q.size() > 0) else begin
					$display("Result appeared with no instruction outstanding");
					fail_count++;
				end
				if (res_q.size() > 0) begin
					exp_out = res_q.pop_front();
					issued_at = res_cyc_q.pop_front();
					assert ((cycle_count - issued_at) == RESULT_LATENCY) else begin
						$display("Result for rd %0d came %0d cycles after its instruction, not %0d",
							exp_out.rd, cycle_count - issued_at, RESULT_LATENCY);
						fail_count++;
					end
					check_field("result.value", exp_out.value, result.value);
					check_field("result.zero", 32'(exp_out.zero), 32'(result.zero));
					check_field("result.sign", 32'(exp_out.sign), 32'(result.sign));
					check_field("result.carry", 32'(exp_out.carry), 32'(result.carry));
					check_field("result.rd", 32'(exp_out.rd), 32'(result.rd));
				end
			end
		end
	end

	// Run limit
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [3:0]  code;
		logic [4:0]  amt;
		logic [4:0]  shamt;
		logic [31:0] val_a;
		logic [31:0] val_b;
		logic [31:0] r;
		int          fails_before;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = 32'd0;
		op_a = 32'd0;
		op_b = 32'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// Each code once, diff and complement edge cases
		fails_before = fail_count;
		issue_instr(reg_form(5'd1, 4'b0000, 5'd0), 32'hdead_beef, 32'h1111_1111);
		issue_instr(reg_form(5'd2, 4'b0010, 5'd0), 32'hf0f0_ff00, 32'h0ff0_f0f0);
		issue_instr(reg_form(5'd3, 4'b0011, 5'd0), 32'hf0f0_ff00, 32'h0ff0_f0f0);
		issue_instr(reg_form(5'd4, 4'b0100, 5'd0), 32'h1234_5678, 32'h1234_5678);
		issue_instr(reg_form(5'd5, 4'b0100, 5'd0), 32'h8000_1234, 32'h0000_1234);
		issue_instr(reg_form(5'd6, 4'b0101, 5'd0), 32'h5555_5555, 32'd0);
		issue_instr(reg_form(5'd7, 4'b0101, 5'd0), 32'h5555_5555, 32'd1);
		issue_instr(reg_form(5'd8, 4'b0001, 5'd0), 32'hffff_ffff, 32'd2);
		drain_pipeline();
		report_test("1 directed codes", fails_before);

		// Carry set, held through non-add ops, cleared by a plain add
		fails_before = fail_count;
		issue_instr(reg_form(5'd1, 4'b0001, 5'd0), 32'h8000_0000, 32'h8000_0000);
		issue_instr(reg_form(5'd2, 4'b0010, 5'd0), 32'hffff_0000, 32'h00ff_ff00);
		issue_instr(reg_form(5'd3, 4'b0011, 5'd0), 32'hffff_0000, 32'h00ff_ff00);
		issue_instr(reg_form(5'd4, 4'b1011, 5'd4), 32'h0000_00f0, 32'd0);
		issue_instr(reg_form(5'd5, 4'b1101, 5'd0), 32'hf000_0000, 32'd8);
		issue_instr(reg_form(5'd6, 4'b0001, 5'd0), 32'd1, 32'd1);
		issue_instr(reg_form(5'd7, 4'b0010, 5'd0), 32'hffff_ffff, 32'h0000_ffff);
		drain_pipeline();
		report_test("2 carry retention", fails_before);

		// All shift codes, amount from shamt or b, unused source holds junk
		fails_before = fail_count;
		for (int c = 8; c < 16; c++) begin
			for (int k = 0; k < 4; k++) begin
				for (int o = 0; o < 2; o++) begin
					code = 4'(c);
					case (k)
						0: amt = 5'd0;
						1: amt = 5'd1;
						2: amt = 5'd13;
						default: amt = 5'd31;
					endcase
					val_a = (o != 0) ? 32'h8765_4321 : 32'h1234_5678;
					if (code[2]) begin
						val_b = {27'h2d2_d2d2, amt};
						shamt = ~amt;
					end else begin
						val_b = {27'h2d2_d2d2, ~amt};
						shamt = amt;
					end
					issue_instr(reg_form(5'(k + 4 * o), code, shamt), val_a, val_b);
				end
			end
		end
		drain_pipeline();
		report_test("3 shifts", fails_before);

		// Negative immediates, one result lands on zero
		fails_before = fail_count;
		issue_instr(addi_form(5'd10, 16'hff9c), 32'd100, 32'hdead_0000);
		issue_instr(addi_form(5'd11, 16'hffff), 32'd5, 32'hdead_0001);
		issue_instr(addi_form(5'd12, 16'h8000), 32'd0, 32'hdead_0002);
		issue_instr(addi_form(5'd13, 16'h7fff), 32'd1, 32'hdead_0003);
		issue_instr(addi_form(5'd14, 16'hfffe), 32'd0, 32'hdead_0004);
		drain_pipeline();
		report_test("4 add immediate", fails_before);

		// Rejects mixed with legal neighbors
		fails_before = fail_count;
		issue_instr(reg_form(5'd1, 4'b0010, 5'd0), 32'h0f0f_0f0f, 32'h00ff_00ff);
		issue_instr(bad_opcode(6'd2, 5'd2), 32'hffff_ffff, 32'd1);
		issue_instr(reg_form(5'd3, 4'b0110, 5'd0), 32'hffff_ffff, 32'd1);
		issue_instr(reg_form(5'd4, 4'b0001, 5'd0), 32'd7, 32'd9);
		issue_instr(reg_form(5'd5, 4'b0111, 5'd0), 32'hffff_ffff, 32'd1);
		issue_instr(bad_opcode(6'd63, 5'd6), 32'hffff_ffff, 32'd1);
		issue_instr(addi_form(5'd7, 16'h0010), 32'd32, 32'd0);
		issue_instr(bad_opcode(6'd2, 5'd8), 32'hffff_ffff, 32'd1);
		issue_instr(reg_form(5'd9, 4'b0011, 5'd0), 32'h1234_5678, 32'h8765_4321);
		drain_pipeline();
		report_test("5 illegal", fails_before);

		// One per cycle, three in flight
		fails_before = fail_count;
		for (int n = 0; n < N_RANDOM; n++) begin
			r = $random(seed);
			val_a = $random(seed);
			val_b = $random(seed);
			if (r[2:0] == 3'd0) begin
				issue_instr(addi_form(r[8:4], r[31:16]), val_a, val_b);
			end else begin
				code = r[12:9];
				// Keep the stream legal
				if (!code[3] && code[2:1] == 2'b11)
					code = 4'b0001;
				issue_instr(reg_form(r[8:4], code, r[17:13]), val_a, val_b);
			end
		end
		drain_pipeline();
		report_test("6 random back to back", fails_before);

		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+source
source/alu_pkg.sv
source/alu_shifter.sv
source/alu_decode.sv
source/alu_execute.sv
source/alu_result.sv
source/alu_top.sv
sim/alu_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module alu_tb -Mdir obj_dir -f all.f

output=$(./obj_dir/Valu_tb 2>&1) || {
	echo "$output"
	echo "Simulation exited with an error"
	exit 1
}

echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
	exit 0
else
	exit 1
fi
